// ==== hdl/led_stretch.sv ====
module led_stretch (
	input  logic CLK125,
	input  logic reset_i,
	input  logic trig_i,
	output logic led_o
);

	import readout_pkg::*;

	// Cycles left to stay lit
	logic [LED_CNT_W-1:0] hold_q;

	//////////////////////////////
	// Hold counter
	//////////////////////////////

	always_ff @(posedge CLK125) begin
		if (reset_i) begin
			hold_q <= '0;
		end else if (trig_i) begin
			// Restart on every active cycle
			hold_q <= LED_CNT_W'(LED_HOLD_CYCLES);
		end else if (hold_q != '0) begin
			hold_q <= hold_q - 1'b1;
		end
	end

	// Lit one cycle after the source
	assign led_o = (hold_q != '0);

endmodule

// ==== hdl/link_led_result.sv ====
module link_led_result (
	input  logic                      CLK125,
	input  logic                      reset_i,
	input  trig_link_pkg::token_evt_t evt_i,
	input  logic                      overflow_i,
	input  logic                      inhibit_i,
	output trig_link_pkg::link_word_t link_o,
	output readout_pkg::led_t         leds_o
);

	import trig_link_pkg::*;

	link_word_t link_q;

	// LED sources
	logic err_src;
	logic trig_src;
	logic live_src;

	// Stretched indicators
	logic err_led;
	logic trig_led;
	logic live_led;

	//////////////////////////////
	// Link word
	//////////////////////////////

	always_ff @(posedge CLK125) begin
		if (reset_i) begin
			link_q <= '{kchar: 1'b1, data: COMMA_WORD};
		end else if (evt_i.valid) begin
			// Token status, tag then err then token
			link_q <= '{kchar: 1'b0, data: {TOKEN_TAG, evt_i.err, evt_i.token}};
		end else begin
			link_q <= '{kchar: 1'b1, data: COMMA_WORD};
		end
	end

	assign link_o = link_q;

	//////////////////////////////
	// Indicators
	//////////////////////////////

	// Bad parity or dropped tokens
	assign err_src  = (evt_i.valid & evt_i.err) | overflow_i;
	assign trig_src = evt_i.valid;
	// Lit while not inhibited
	assign live_src = ~inhibit_i;

	led_stretch u_err_led (
		.CLK125  (CLK125),
		.reset_i (reset_i),
		.trig_i  (err_src),
		.led_o   (err_led)
	);

	led_stretch u_trig_led (
		.CLK125  (CLK125),
		.reset_i (reset_i),
		.trig_i  (trig_src),
		.led_o   (trig_led)
	);

	led_stretch u_live_led (
		.CLK125  (CLK125),
		.reset_i (reset_i),
		.trig_i  (live_src),
		.led_o   (live_led)
	);

	assign leds_o = '{err: err_led, trig: trig_led, live: live_led};

endmodule

// ==== hdl/readout_pkg.sv ====
package readout_pkg;

	//////////////////////////////
	// Readout record
	//////////////////////////////

	// Sequence number, wraps at 32
	localparam int SEQ_W = 5;

	// Record sent toward the memory FIFO
	typedef struct packed {
		logic                             err;
		logic [SEQ_W-1:0]                 seq;
		logic [trig_link_pkg::TOKEN_W-1:0] token;
	} record_t;

	//////////////////////////////
	// Queue and credits
	//////////////////////////////

	// Records held while credits are out
	localparam int QUEUE_DEPTH = 4;
	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	// Fill level, 0 to QUEUE_DEPTH
	localparam int QCNT_W = $clog2(QUEUE_DEPTH + 1);

	// Credits held after reset
	localparam int CREDIT_INIT = 8;
	localparam int CREDIT_W = 4;

	//////////////////////////////
	// Indicators
	//////////////////////////////

	// Cycles an LED stays lit after its source drops
	localparam int LED_HOLD_CYCLES = 32;
	localparam int LED_CNT_W = $clog2(LED_HOLD_CYCLES + 1);

	typedef struct packed {
		logic err;
		logic trig;
		logic live;
	} led_t;

endpackage

// ==== hdl/token_dist_top.sv ====
module token_dist_top (
	input  logic                      CLK125,
	input  logic                      reset_i,
	input  logic                      ser_trig_i,
	input  logic                      inhibit_i,
	input  logic                      enable_i,
	input  logic                      credit_i,
	output readout_pkg::record_t      rec_o,
	output logic                      rec_valid_o,
	output trig_link_pkg::link_word_t link_o,
	output readout_pkg::led_t         leds_o
);

	import trig_link_pkg::*;

	// Decoded token, shared by execute and result
	token_evt_t evt;
	// Sticky drop flag toward the error LED
	logic       overflow;

	//////////////////////////////
	// Decode
	//////////////////////////////

	trig_frame_decode u_decode (
		.CLK125     (CLK125),
		.reset_i    (reset_i),
		.ser_trig_i (ser_trig_i),
		.evt_o      (evt)
	);

	//////////////////////////////
	// Execute
	//////////////////////////////

	token_record_execute u_execute (
		.CLK125      (CLK125),
		.reset_i     (reset_i),
		.evt_i       (evt),
		.inhibit_i   (inhibit_i),
		.enable_i    (enable_i),
		.credit_i    (credit_i),
		.rec_o       (rec_o),
		.rec_valid_o (rec_valid_o),
		.overflow_o  (overflow)
	);

	//////////////////////////////
	// Result
	//////////////////////////////

	link_led_result u_result (
		.CLK125     (CLK125),
		.reset_i    (reset_i),
		.evt_i      (evt),
		.overflow_i (overflow),
		.inhibit_i  (inhibit_i),
		.link_o     (link_o),
		.leds_o     (leds_o)
	);

endmodule

// ==== hdl/token_record_execute.sv ====
module token_record_execute (
	input  logic                      CLK125,
	input  logic                      reset_i,
	input  trig_link_pkg::token_evt_t evt_i,
	input  logic                      inhibit_i,
	input  logic                      enable_i,
	input  logic                      credit_i,
	output readout_pkg::record_t      rec_o,
	output logic                      rec_valid_o,
	output logic                      overflow_o
);

	import readout_pkg::*;

	// Record storage
	record_t            queue_mem [QUEUE_DEPTH];
	logic [PTR_W-1:0]   wr_ptr_q;
	logic [PTR_W-1:0]   rd_ptr_q;
	logic [QCNT_W-1:0]  count_q;
	logic [SEQ_W-1:0]   seq_q;
	logic [CREDIT_W-1:0] credit_q;
	logic               overflow_q;

	logic               accept;
	logic               full;
	logic               push;
	logic               drop;
	logic               send;

	// Circular pointer step
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	//////////////////////////////
	// Gating
	//////////////////////////////

	// Error tokens are recorded as well
	assign accept = evt_i.valid & enable_i & ~inhibit_i;
	assign full   = (count_q == QCNT_W'(QUEUE_DEPTH));
	assign push   = accept & ~full;
	// Full queue drops the token and keeps the sequence number
	assign drop   = accept & full;
	// One record per cycle while credits remain
	assign send   = (count_q != '0) && (credit_q != '0);

	//////////////////////////////
	// Queue
	//////////////////////////////

	always_ff @(posedge CLK125) begin
		if (push) begin
			queue_mem[wr_ptr_q] <= '{err: evt_i.err, seq: seq_q, token: evt_i.token};
		end
	end

	always_ff @(posedge CLK125) begin
		if (reset_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
			seq_q    <= '0;
		end else begin
			if (push) begin
				wr_ptr_q <= next_ptr(wr_ptr_q);
				// Wraps at 32 by width
				seq_q    <= seq_q + 1'b1;
			end
			if (send) begin
				rd_ptr_q <= next_ptr(rd_ptr_q);
			end
			// Fill level
			case ({push, send})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	//////////////////////////////
	// Credits and overflow
	//////////////////////////////

	always_ff @(posedge CLK125) begin
		if (reset_i) begin
			credit_q   <= CREDIT_W'(CREDIT_INIT);
			overflow_q <= 1'b0;
		end else begin
			// Send and return together cancel out
			case ({send, credit_i})
				2'b10:   credit_q <= credit_q - 1'b1;
				2'b01:   credit_q <= credit_q + 1'b1;
				default: credit_q <= credit_q;
			endcase
			// Sticky until reset
			if (drop) begin
				overflow_q <= 1'b1;
			end
		end
	end

	// Head of queue drives the record port
	assign rec_o       = queue_mem[rd_ptr_q];
	assign rec_valid_o = send;
	assign overflow_o  = overflow_q;

endmodule

// ==== hdl/trig_frame_decode.sv ====
module trig_frame_decode (
	input  logic                      CLK125,
	input  logic                      reset_i,
	input  logic                      ser_trig_i,
	output trig_link_pkg::token_evt_t evt_o
);

	import trig_link_pkg::*;

	// Waiting for start bit, or inside a frame
	typedef enum logic {
		ST_IDLE,
		ST_RECV
	} state_t;

	state_t                 state_q;
	logic [BIT_CNT_W-1:0]   bit_cnt_q;
	logic [TOKEN_W-1:0]     shift_q;
	logic                   parity_q;
	logic                   last_bit;

	// Event register fields
	logic                   valid_q;
	logic [TOKEN_W-1:0]     token_q;
	logic                   err_q;

	// Parity bit on the line this cycle
	assign last_bit = (state_q == ST_RECV) &&
		(bit_cnt_q == BIT_CNT_W'(FRAME_BITS - 1));

	//////////////////////////////
	// Frame FSM
	//////////////////////////////

	always_ff @(posedge CLK125) begin
		if (reset_i) begin
			state_q   <= ST_IDLE;
			bit_cnt_q <= '0;
			valid_q   <= 1'b0;
		end else begin
			// Event lasts one cycle only
			valid_q <= 1'b0;
			case (state_q)
				ST_IDLE: begin
					// Line idles low, a 1 opens a frame
					if (ser_trig_i) begin
						state_q   <= ST_RECV;
						bit_cnt_q <= '0;
					end
				end
				ST_RECV: begin
					bit_cnt_q <= bit_cnt_q + 1'b1;
					if (last_bit) begin
						valid_q <= 1'b1;
						// Back-to-back start bit is caught from idle
						state_q <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	//////////////////////////////
	// Shift and parity
	//////////////////////////////

	always_ff @(posedge CLK125) begin
		if (state_q == ST_IDLE) begin
			parity_q <= 1'b0;
		end else begin
			parity_q <= parity_q ^ ser_trig_i;
			// Token bits come first, MSB first
			if (bit_cnt_q < BIT_CNT_W'(TOKEN_W)) begin
				shift_q <= {shift_q[TOKEN_W-2:0], ser_trig_i};
			end
		end
		// Capture at the edge that samples parity
		if (last_bit) begin
			token_q <= shift_q;
			// Even parity expected, odd total is an error
			err_q   <= parity_q ^ ser_trig_i;
		end
	end

	assign evt_o = '{valid: valid_q, token: token_q, err: err_q};

endmodule

// ==== hdl/trig_link_pkg.sv ====
package trig_link_pkg;

	//////////////////////////////
	// Serial trigger frame
	//////////////////////////////

	// Token width in bits
	localparam int TOKEN_W = 10;

	// Bits after the start bit, token MSB first then even parity
	localparam int FRAME_BITS = 11;

	// Bit counter inside a frame
	localparam int BIT_CNT_W = $clog2(FRAME_BITS);

	// Decoded token, valid for one cycle
	typedef struct packed {
		logic               valid;
		logic [TOKEN_W-1:0] token;
		// Odd parity seen over token plus parity bit
		logic               err;
	} token_evt_t;

	//////////////////////////////
	// Outgoing link word
	//////////////////////////////

	// Link data width
	localparam int LINK_W = 16;

	// Idle data, sent with kchar set
	localparam logic [LINK_W-1:0] COMMA_WORD = 16'h00BC;

	// Upper bits of a token status word
	localparam logic [4:0] TOKEN_TAG = 5'b10000;

	// One link beat
	typedef struct packed {
		// High for comma, low for token status
		logic              kchar;
		logic [LINK_W-1:0] data;
	} link_word_t;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the token path testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module tb_top -f vlog.f -o tb_sim

# The simulator exit status is judged through the log below
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test FAILED" sim.log; then
	exit 1
fi
if ! grep -q "Test OK" sim.log; then
	echo "simulation ended without a result, see sim.log"
	exit 1
fi

// ==== verification/tb_clock_gen.sv ====
module tb_clock_gen (
	output logic CLK125,
	output logic reset_o
);

	// Period of 10 time units
	initial begin
		CLK125 = 1'b0;
		forever #5 CLK125 = ~CLK125;
	end

	// Reset high for 10 rising edges, released on a falling edge
	initial begin
		reset_o = 1'b1;
		repeat (10) @(posedge CLK125);
		@(negedge CLK125);
		reset_o = 1'b0;
	end

endmodule

// ==== verification/tb_top.sv ====
module tb_top;

	import trig_link_pkg::*;
	import readout_pkg::*;

	// Frames per phase
	localparam int N_IDLE_CYC = 50;
	localparam int N_RANDOM   = 36;
	localparam int N_BAD      = 4;
	localparam int N_GATED    = 6;
	localparam int N_BURST    = 15;
	localparam int N_FRAMES   = N_RANDOM + N_BAD + N_GATED + N_BURST;

	logic       CLK125;
	logic       reset_i;
	logic       ser_trig_i;
	logic       inhibit_i;
	logic       enable_i;
	logic       credit_i;
	record_t    rec_o;
	logic       rec_valid_o;
	link_word_t link_o;
	led_t       leds_o;

	// Expected outputs, oldest first
	record_t          exp_rec[$];
	link_word_t       exp_link[$];
	logic [SEQ_W-1:0] model_seq;
	// Records received but not yet credited back
	int               owed;
	int               rec_seen;
	logic             credit_en;

	tb_clock_gen u_clk (
		.CLK125  (CLK125),
		.reset_o (reset_i)
	);

	token_dist_top dut (
		.CLK125      (CLK125),
		.reset_i     (reset_i),
		.ser_trig_i  (ser_trig_i),
		.inhibit_i   (inhibit_i),
		.enable_i    (enable_i),
		.credit_i    (credit_i),
		.rec_o       (rec_o),
		.rec_valid_o (rec_valid_o),
		.link_o      (link_o),
		.leds_o      (leds_o)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("ERR %0t %s got %h expected %h", $time, name, got, expected);
			abort_run("compare failed");
		end
	endtask

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// Err is odd parity over token and parity bit
	function automatic record_t ref_record(input logic [TOKEN_W-1:0] tok, input logic par,
		input logic [SEQ_W-1:0] seq);
		ref_record = '{err: ^{tok, par}, seq: seq, token: tok};
	endfunction

	// Tag, err, token
	function automatic link_word_t ref_link(input logic [TOKEN_W-1:0] tok, input logic par);
		ref_link = '{kchar: 1'b0, data: {TOKEN_TAG, ^{tok, par}, tok}};
	endfunction

	// Start bit, token MSB first, parity; keep means a record is expected
	task automatic send_frame(input logic [TOKEN_W-1:0] tok, input logic bad, input bit keep);
		logic par;
		par = (^tok) ^ bad;
		exp_link.push_back(ref_link(tok, par));
		if (keep) begin
			exp_rec.push_back(ref_record(tok, par, model_seq));
			model_seq = model_seq + 1'b1;
		end
		@(negedge CLK125);
		ser_trig_i = 1'b1;
		for (int i = TOKEN_W - 1; i >= 0; i--) begin
			@(negedge CLK125);
			ser_trig_i = tok[i];
		end
		@(negedge CLK125);
		ser_trig_i = par;
	endtask

	// Zero cycles keeps the next start bit back to back
	task automatic idle_line(input int cycles);
		repeat (cycles) begin
			@(negedge CLK125);
			ser_trig_i = 1'b0;
		end
	endtask

	task automatic wait_drained();
		while (exp_rec.size() != 0 || exp_link.size() != 0 || owed != 0) begin
			@(negedge CLK125);
		end
		@(negedge CLK125);
	endtask

	//////////////////////////////
	// Compare and credit return
	//////////////////////////////

	always @(negedge CLK125) begin
		if (!reset_i) begin
			// Comma in every cycle without a token word
			if (link_o.kchar) begin
				check_value("link_o.data", 32'(link_o.data), 32'(COMMA_WORD));
			end else if (exp_link.size() == 0) begin
				abort_run("link carried a token word with no frame sent");
			end else begin
				check_value("link_o", 32'(link_o), 32'(exp_link.pop_front()));
			end
			// Return credits for earlier records only
			if (credit_en && owed > 0) begin
				credit_i = 1'b1;
				owed--;
			end else begin
				credit_i = 1'b0;
			end
			if (rec_valid_o) begin
				rec_seen++;
				owed++;
				if (exp_rec.size() == 0) begin
					abort_run("record appeared with no accepted token");
				end else begin
					check_value("rec_o", 32'(rec_o), 32'(exp_rec.pop_front()));
				end
			end
		end
	end

	// Watchdog sized from the frame count
	initial begin
		repeat (N_FRAMES * 40 + 2000) @(posedge CLK125);
		abort_run("timeout, the DUT did not deliver all expected outputs in time");
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	initial begin
		logic [31:0] rnd;
		int          base;
		rnd        = $urandom(32'h754c);
		ser_trig_i = 1'b0;
		inhibit_i  = 1'b0;
		enable_i   = 1'b1;
		credit_i   = 1'b0;
		credit_en  = 1'b1;
		owed       = 0;
		rec_seen   = 0;
		model_seq  = '0;
		wait (!reset_i);
		// Quiet line, comma only
		repeat (N_IDLE_CYC) @(negedge CLK125);
		// Good parity, random gaps, sequence wraps past 32
		for (int n = 0; n < N_RANDOM; n++) begin
			rnd = $urandom();
			send_frame(rnd[TOKEN_W-1:0], 1'b0, 1'b1);
			idle_line(int'(rnd[12:11]));
		end
		// Wrong parity
		for (int n = 0; n < N_BAD; n++) begin
			rnd = $urandom();
			send_frame(rnd[TOKEN_W-1:0], 1'b1, 1'b1);
			idle_line(3);
		end
		check_value("leds_o.err", 32'(leds_o.err), 32'd1);
		// Inhibit, then enable low; link words only
		inhibit_i = 1'b1;
		idle_line(LED_HOLD_CYCLES + 4);
		check_value("leds_o.live", 32'(leds_o.live), 32'd0);
		for (int n = 0; n < N_GATED; n++) begin
			rnd = $urandom();
			if (n == N_GATED / 2) begin
				inhibit_i = 1'b0;
				enable_i  = 1'b0;
			end
			send_frame(rnd[TOKEN_W-1:0], 1'b0, 1'b0);
			idle_line(2);
		end
		enable_i = 1'b1;
		idle_line(4);
		check_value("leds_o.live", 32'(leds_o.live), 32'd1);
		// Credits withheld, queue fills and drops the tail
		wait_drained();
		credit_en = 1'b0;
		base      = rec_seen;
		for (int n = 0; n < N_BURST; n++) begin
			rnd = $urandom();
			send_frame(rnd[TOKEN_W-1:0], 1'b0, n < CREDIT_INIT + QUEUE_DEPTH);
		end
		idle_line(20);
		check_value("records before credit", 32'(rec_seen - base), 32'(CREDIT_INIT));
		check_value("leds_o.err", 32'(leds_o.err), 32'd1);
		credit_en = 1'b1;
		wait_drained();
		check_value("records after credit", 32'(rec_seen - base),
			32'(CREDIT_INIT + QUEUE_DEPTH));
		// Quiet line lets the trigger LED expire
		idle_line(LED_HOLD_CYCLES + 4);
		check_value("leds_o.trig", 32'(leds_o.trig), 32'd0);
		if (exp_rec.size() != 0 || exp_link.size() != 0) begin
			abort_run("expected outputs still pending at the end");
		end else begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

// ==== verification/token_dist_checker.sv ====
module token_dist_checker (
	input logic                           CLK125,
	input logic                           reset_i,
	input logic                           rec_valid_i,
	input logic                           credit_i,
	input logic                           overflow_i,
	input logic [readout_pkg::QCNT_W-1:0] queue_cnt_i
);

	import readout_pkg::*;

	// Records sent and not yet credited back
	int outstanding_q;

	//////////////////////////////
	// Credit rule
	//////////////////////////////

	// Counted from the port handshake alone
	always_ff @(posedge CLK125) begin
		if (reset_i) begin
			outstanding_q <= 0;
		end else begin
			outstanding_q <= outstanding_q + int'(rec_valid_i) - int'(credit_i);
		end
	end

	// A send needs a credit in hand
	property p_send_has_credit;
		@(posedge CLK125) disable iff (reset_i)
		rec_valid_i |-> (outstanding_q < CREDIT_INIT);
	endproperty

	a_send_has_credit: assert property (p_send_has_credit)
		else $error("record sent with zero credits");

	//////////////////////////////
	// Overflow and fill level
	//////////////////////////////

	// Only reset clears the sticky flag
	property p_overflow_sticky;
		@(posedge CLK125) disable iff (reset_i)
		overflow_i |=> overflow_i;
	endproperty

	a_overflow_sticky: assert property (p_overflow_sticky)
		else $error("overflow flag fell without reset");

	// Never more records than slots
	property p_queue_bound;
		@(posedge CLK125) disable iff (reset_i)
		queue_cnt_i <= QCNT_W'(QUEUE_DEPTH);
	endproperty

	a_queue_bound: assert property (p_queue_bound)
		else $error("record queue above its depth");

endmodule

bind token_record_execute token_dist_checker u_checker (
	.CLK125      (CLK125),
	.reset_i     (reset_i),
	.rec_valid_i (rec_valid_o),
	.credit_i    (credit_i),
	.overflow_i  (overflow_o),
	.queue_cnt_i (count_q)
);

// ==== vlog.f ====
hdl/trig_link_pkg.sv
hdl/readout_pkg.sv
hdl/trig_frame_decode.sv
hdl/token_record_execute.sv
hdl/led_stretch.sv
hdl/link_led_result.sv
hdl/token_dist_top.sv
verification/tb_clock_gen.sv
verification/token_dist_checker.sv
verification/tb_top.sv
